// File: build.f
+incdir+rtl
rtl/rvExecPkg.sv
rtl/execIfs.sv
rtl/aluControl.sv
rtl/immGen.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/execRetire.sv
rtl/rvExecUnit.sv
dv/rvExecUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module rvExecUnitTb -f build.f
out=$(./obj_dir/VrvExecUnitTb) || true
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

// File: dv/rvExecUnitTb.sv
`default_nettype none

`include "rvExec_defs.svh"

module rvExecUnitTb import rvExecPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// what one instruction should produce
	typedef struct packed {
		word_t    result;
		logic     chkResult; // off for branches and illegal opcodes
		logic     wr;
		regAddr_t rd;
		logic     taken;
		logic     isBr;
		word_t    target;
		logic     ill;
	} outcome_t;

	logic     clk;
	logic     arstN;
	logic     instrValid;
	word_t    instr;
	word_t    pc;
	logic     resultValid;
	word_t    result;
	logic     rdWrite;
	regAddr_t rdAddr;
	logic     branchTaken;
	word_t    branchTarget;
	logic     illegal;

	integer   seed = 32'h8235_35e6;
	word_t    model [32];  // register contents as the model sees them
	outcome_t pending [$]; // issued and still awaiting a result

	rvExecUnit dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkReg(string name, regAddr_t got, regAddr_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	function automatic word_t nextRand();
		return $random(seed);
	endfunction

	function automatic word_t encR(funct3_t f3, logic alt, regAddr_t rd, regAddr_t rs1,
		regAddr_t rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_R};
	endfunction

	function automatic word_t encI(logic [6:0] opc, funct3_t f3, regAddr_t rd, regAddr_t rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t encS(funct3_t f3, regAddr_t rs1, regAddr_t rs2, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_S};
	endfunction

	function automatic word_t encB(funct3_t f3, regAddr_t rs1, regAddr_t rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_B};
	endfunction

	// R and I operations where bit 30 only counts for sub and sra
	function automatic word_t aluRef(funct3_t f3, logic alt, logic isR, word_t x, word_t y);
		case (f3)
			3'b000: return (isR && alt) ? x - y : x + y;
			3'b001: return x << y[4:0];
			3'b010: return {31'b0, $signed(x) < $signed(y)};
			3'b011: return isR ? {31'b0, x < y} : x + y; // sltiu falls back to add
			3'b100: return x ^ y;
			3'b101: return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'b110: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branchRef(funct3_t f3, word_t x, word_t y);
		case (f3)
			3'b000: return x == y;
			3'b001: return x != y;
			3'b100: return $signed(x) < $signed(y);
			3'b101: return $signed(x) >= $signed(y);
			3'b110: return x < y;
			default: return 1'b0; // bgeu never branches
		endcase
	endfunction

	function automatic outcome_t predict(word_t ins, word_t p);
		outcome_t e;
		word_t    a;
		word_t    b;
		funct3_t  f3;
		a = model[ins[19:15]];
		b = model[ins[24:20]];
		f3 = ins[14:12];
		e = '0;
		e.rd = ins[11:7];
		e.chkResult = 1'b1;
		case (ins[6:0])
			`OPC_R:
			begin
				e.wr = 1'b1;
				e.result = aluRef(f3, ins[30], 1'b1, a, b);
			end
			`OPC_I:
			begin
				e.wr = 1'b1;
				e.result = aluRef(f3, ins[30], 1'b0, a, word_t'($signed(ins[31:20])));
			end
			`OPC_L: e.result = a + word_t'($signed(ins[31:20]));
			`OPC_S: e.result = a + word_t'($signed({ins[31:25], ins[11:7]}));
			`OPC_B:
			begin
				e.chkResult = 1'b0;
				e.isBr = 1'b1;
				e.taken = branchRef(f3, a, b);
				e.target = p + word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
			end
			default:
			begin
				e.chkResult = 1'b0; // result is don't-care
				e.ill = 1'b1;
			end
		endcase
		return e;
	endfunction

	task automatic collect(outcome_t e);
		int n;
		n = 0;
		while (resultValid !== 1'b1)
		begin
			if (n == 10)
			begin
				$display("timeout, no valid result within 10 cycles");
				abortRun();
			end
			@(negedge clk);
			n++;
		end
		checkReg("rdAddr", rdAddr, e.rd);
		checkBit("rdWrite", rdWrite, e.wr);
		checkBit("branchTaken", branchTaken, e.taken);
		checkBit("illegal", illegal, e.ill);
		if (e.chkResult)
			checkWord("result", result, e.result);
		if (e.isBr)
			checkWord("branchTarget", branchTarget, e.target);
	endtask

	// drive one instruction and check the one issued a cycle earlier
	task automatic issue(word_t ins, word_t p);
		outcome_t e;
		e = predict(ins, p);
		if (e.wr && e.rd != '0)
			model[e.rd] = e.result;
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= ins;
		pc         <= p;
		@(negedge clk);
		if (pending.size() > 0)
			collect(pending.pop_front());
		pending.push_back(e);
	endtask

	task automatic drain();
		@(posedge clk);
		instrValid <= 1'b0;
		@(negedge clk);
		if (pending.size() > 0)
			collect(pending.pop_front());
		@(negedge clk);
		checkBit("resultValid", resultValid, 1'b0); // nothing left in flight
	endtask

	initial
	begin
		word_t       w;
		word_t       w2;
		funct3_t     f3;
		regAddr_t    rs1;
		logic [6:0]  opc;
		logic [11:0] imm12;
		int          i;
		for (i = 0; i < 32; i++)
			model[i] = '0;
		arstN      <= 1'b0;
		instrValid <= 1'b1; // a write during reset must not land
		instr      <= encI(`OPC_I, 3'b000, 5'd1, 5'd0, 12'h7ff);
		pc         <= '0;
		repeat (5) @(posedge clk);
		arstN      <= 1'b1;
		instrValid <= 1'b0;
		@(negedge clk);
		checkBit("resultValid", resultValid, 1'b0);
		checkBit("rdWrite", rdWrite, 1'b0);
		checkBit("branchTaken", branchTaken, 1'b0);
		checkBit("illegal", illegal, 1'b0);
		issue(encR(3'b000, 1'b0, 5'd3, 5'd1, 5'd2), '0); // cleared registers add to zero

		for (i = 1; i < 32; i++)
		begin
			w = nextRand();
			issue(encI(`OPC_I, 3'b000, regAddr_t'(i), w[19:15], w[31:20]), '0);
		end
		for (i = 0; i < 40; i++)
		begin
			w = nextRand();
			f3 = w[14:12];
			issue(encR(f3, w[30] && (f3 == 3'b000 || f3 == 3'b101), w[11:7], w[19:15],
				w[24:20]), '0);
		end
		issue(encR(3'b000, 1'b0, 5'd0, 5'd1, 5'd2), '0); // x0 write is reported
		issue(encR(3'b000, 1'b0, 5'd7, 5'd0, 5'd0), '0); // but reads back zero

		for (i = 0; i < 30; i++)
		begin
			w = nextRand();
			f3 = w[14:12];
			if (f3 inside {3'b000, 3'b010, 3'b011})
				f3 = 3'b110;
			if (f3 == 3'b001 || f3 == 3'b101)
				imm12 = {1'b0, w[30] && f3 == 3'b101, 5'b0, w[24:20]};
			else
				imm12 = {1'b1, w[30:20]}; // negative immediate
			issue(encI(`OPC_I, f3, w[11:7], w[19:15], imm12), '0);
		end

		for (i = 0; i < 20; i++)
		begin
			w = nextRand();
			if (w[0])
				issue(encI(`OPC_L, 3'b010, w[11:7], w[19:15], w[31:20]), '0);
			else
				issue(encS(3'b010, w[19:15], w[24:20], w[31:20]), '0);
		end

		for (i = 0; i < 40; i++)
		begin
			w = nextRand();
			w2 = nextRand();
			f3 = w[14:12];
			if (f3 inside {3'b010, 3'b011, 3'b111})
				f3 = 3'b000;
			rs1 = w[19:15];
			issue(encB(f3, rs1, w[25] ? rs1 : w[24:20], {w2[12:1], 1'b0}), {w2[31:2], 2'b00});
		end

		for (i = 0; i < 15; i++)
		begin
			w = nextRand();
			opc = w[6:0];
			if (opc inside {`OPC_R, `OPC_I, `OPC_L, `OPC_S, `OPC_B})
				opc = opc ^ 7'b0000100; // lands on an unsupported opcode
			issue({w[31:7], opc}, '0);
			issue(encR(3'b000, 1'b0, 5'd0, w[11:7], 5'd0), '0);
		end

		drain();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/rvExecUnit.sv
`default_nettype none

module rvExecUnit import rvExecPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  logic     instrValid,
	input  word_t    instr,
	input  word_t    pc,
	output logic     resultValid,
	output word_t    result,
	output logic     rdWrite,
	output regAddr_t rdAddr,
	output logic     branchTaken,
	output word_t    branchTarget,
	output logic     illegal
);
	regAddr_t rs1Addr;
	regAddr_t rs2Addr;
	word_t    rs1Data;
	word_t    rs2Data;
	logic     wrEn;
	regAddr_t wrAddr;
	word_t    wrData;

	aluCmdIf aluCmdBus ();
	retireIf retireBus ();

	instrDecode decode0
	(
		.instrValid (instrValid),
		.instr      (instr),
		.pc         (pc),
		.rs1Addr    (rs1Addr),
		.rs2Addr    (rs2Addr),
		.rs1Data    (rs1Data),
		.rs2Data    (rs2Data),
		.aluCmd     (aluCmdBus.issue),
		.retire     (retireBus.issue)
	);

	regFile regs0
	(
		.clk     (clk),
		.arstN   (arstN),
		.rs1Addr (rs1Addr),
		.rs2Addr (rs2Addr),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	alu alu0
	(
		.aluCmd (aluCmdBus.exec)
	);

	execRetire retire0
	(
		.clk          (clk),
		.arstN        (arstN),
		.retire       (retireBus.retire),
		.aluResult    (aluCmdBus.result),
		.aluCond      (aluCmdBus.cond),
		.wrEn         (wrEn),
		.wrAddr       (wrAddr),
		.wrData       (wrData),
		.resultValid  (resultValid),
		.result       (result),
		.rdWrite      (rdWrite),
		.rdAddr       (rdAddr),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.illegal      (illegal)
	);

endmodule

`default_nettype wire

// File: rtl/execRetire.sv
`default_nettype none

module execRetire import rvExecPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	retireIf.retire  retire,
	input  word_t    aluResult,
	input  logic     aluCond,
	output logic     wrEn,
	output regAddr_t wrAddr,
	output word_t    wrData,
	output logic     resultValid,
	output word_t    result,
	output logic     rdWrite,
	output regAddr_t rdAddr,
	output logic     branchTaken,
	output word_t    branchTarget,
	output logic     illegal
);
	// register write lands on the same edge that loads the outputs
	assign wrEn   = retire.valid & retire.regWrite & ~retire.illegal;
	assign wrAddr = retire.rd;
	assign wrData = aluResult;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			resultValid <= 1'b0;
			rdWrite     <= 1'b0;
			branchTaken <= 1'b0;
			illegal     <= 1'b0;
		end
		else
		begin
			resultValid <= retire.valid;
			rdWrite     <= wrEn; // includes x0 targets
			branchTaken <= retire.valid & retire.isBranch & aluCond;
			illegal     <= retire.valid & retire.illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		if (retire.valid)
		begin
			result       <= aluResult;
			rdAddr       <= retire.rd;
			branchTarget <= retire.target;
		end
	end

	takenWithValid: assert property (@(posedge clk) disable iff (!arstN)
		$rose(branchTaken) |-> resultValid)
		else $error("branchTaken rose outside a valid result cycle");

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

`include "rvExec_defs.svh"

module alu import rvExecPkg::*;
(
	aluCmdIf.exec aluCmd
);
	word_t      diff;
	logic       lt;
	logic       ltu;
	logic [4:0] shamt;
	logic       isCmp;

	assign diff  = aluCmd.opA - aluCmd.opB;
	assign lt    = $signed(aluCmd.opA) < $signed(aluCmd.opB);
	assign ltu   = aluCmd.opA < aluCmd.opB;
	assign shamt = aluCmd.opB[4:0];

	always_comb
	begin
		aluCmd.cond = 1'b0;
		case (aluCmd.ctrl)
			`ALU_ADD: aluCmd.result = aluCmd.opA + aluCmd.opB;
			`ALU_OR:  aluCmd.result = aluCmd.opA | aluCmd.opB;
			`ALU_AND: aluCmd.result = aluCmd.opA & aluCmd.opB;
			`ALU_XOR: aluCmd.result = aluCmd.opA ^ aluCmd.opB;
			`ALU_SLL: aluCmd.result = aluCmd.opA << shamt;
			`ALU_SRL: aluCmd.result = aluCmd.opA >> shamt;
			`ALU_SRA: aluCmd.result = word_t'($signed(aluCmd.opA) >>> shamt);
			`ALU_SUBEQ:
			begin
				aluCmd.result = diff; // sub and beq
				aluCmd.cond   = (diff == '0);
			end
			`ALU_NE:
			begin
				aluCmd.result = diff;
				aluCmd.cond   = (diff != '0);
			end
			`ALU_SLT:
			begin
				aluCmd.result = {31'b0, lt};
				aluCmd.cond   = lt;
			end
			`ALU_GE:
			begin
				aluCmd.result = {31'b0, ~lt};
				aluCmd.cond   = ~lt;
			end
			`ALU_SLTU:
			begin
				aluCmd.result = {31'b0, ltu};
				aluCmd.cond   = ltu;
			end
			default: aluCmd.result = aluCmd.opA + aluCmd.opB; // unused codes
		endcase
	end

	assign isCmp = aluCmd.ctrl inside {`ALU_SUBEQ, `ALU_NE, `ALU_SLT, `ALU_GE, `ALU_SLTU};

	always_comb
	begin
		assert (isCmp || !aluCmd.cond) else $error("cond set for a non-compare code");
	end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`default_nettype none

module regFile import rvExecPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  regAddr_t rs1Addr,
	input  regAddr_t rs2Addr,
	output word_t    rs1Data,
	output word_t    rs2Data,
	input  logic     wrEn,
	input  regAddr_t wrAddr,
	input  word_t    wrData
);
	word_t regs [32];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn && wrAddr != '0) // x0 is hardwired
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// combinational reads, a write shows up the cycle after
	assign rs1Data = regs[rs1Addr];
	assign rs2Data = regs[rs2Addr];

	x0StaysZero: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0)
		else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: rtl/instrDecode.sv
`default_nettype none

`include "rvExec_defs.svh"

module instrDecode import rvExecPkg::*;
(
	input  logic     instrValid,
	input  word_t    instr,
	input  word_t    pc,
	output regAddr_t rs1Addr,
	output regAddr_t rs2Addr,
	input  word_t    rs1Data,
	input  word_t    rs2Data,
	aluCmdIf.issue   aluCmd,
	retireIf.issue   retire
);
	aluOp_t   aluOp;
	logic     known;
	word_t    imm;
	aluCtrl_t ctrl;

	always_comb
	begin
		known = 1'b1;
		case (instr[6:0])
			`OPC_R: aluOp = `ALUOP_R;
			`OPC_I: aluOp = `ALUOP_I;
			`OPC_L: aluOp = `ALUOP_L;
			`OPC_S: aluOp = `ALUOP_S;
			`OPC_B: aluOp = `ALUOP_B;
			default:
			begin
				aluOp = `ALUOP_R; // any class, nothing retires
				known = 1'b0;
			end
		endcase
	end

	aluControl ctrl0
	(
		.aluOp (aluOp),
		.bits  ({instr[30], instr[14:12]}),
		.ctrl  (ctrl)
	);

	immGen imm0
	(
		.instr (instr),
		.aluOp (aluOp),
		.imm   (imm)
	);

	assign rs1Addr = instr[19:15];
	assign rs2Addr = instr[24:20];

	assign aluCmd.ctrl = ctrl;
	assign aluCmd.opA  = rs1Data;
	assign aluCmd.opB  = (aluOp == `ALUOP_R || aluOp == `ALUOP_B) ? rs2Data : imm;

	assign retire.valid    = instrValid;
	assign retire.regWrite = known && (aluOp == `ALUOP_R || aluOp == `ALUOP_I);
	assign retire.rd       = instr[11:7];
	assign retire.isBranch = known && (aluOp == `ALUOP_B);
	assign retire.illegal  = ~known;
	assign retire.target   = pc + imm; // imm is the B immediate for branches

	// an unknown opcode must never reach the register file
	always_comb
	begin
		if (retire.illegal)
			assert (!retire.regWrite) else $error("illegal opcode flagged for write-back");
	end

endmodule

`default_nettype wire

// File: rtl/immGen.sv
`default_nettype none

`include "rvExec_defs.svh"

module immGen import rvExecPkg::*;
(
	input  word_t  instr,
	input  aluOp_t aluOp,
	output word_t  imm
);
	word_t immI;
	word_t immS;
	word_t immB;

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};

	// B format, bit 0 is always zero
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb
	begin
		case (aluOp)
			`ALUOP_I, `ALUOP_L: imm = immI;
			`ALUOP_S:           imm = immS;
			`ALUOP_B:           imm = immB;
			default:            imm = '0; // R class uses rs2
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/aluControl.sv
`default_nettype none

`include "rvExec_defs.svh"

module aluControl import rvExecPkg::*;
(
	input  aluOp_t     aluOp,
	input  logic [3:0] bits, // {instr[30], funct3}
	output aluCtrl_t   ctrl
);
	funct3_t funct3;
	logic    alt;
	logic    isR;

	assign funct3 = bits[2:0];
	assign alt    = bits[3];
	assign isR    = (aluOp == `ALUOP_R);

	always_comb
	begin
		ctrl = `ALU_ADD; // default for unmapped cases
		case (aluOp)
			`ALUOP_R, `ALUOP_I:
			begin
				// R and I share the table, I has no sub and no sltiu
				case (funct3)
					3'b000: ctrl = (isR && alt) ? `ALU_SUBEQ : `ALU_ADD;
					3'b001: ctrl = `ALU_SLL;
					3'b010: ctrl = `ALU_SLT;
					3'b011: ctrl = isR ? `ALU_SLTU : `ALU_ADD;
					3'b100: ctrl = `ALU_XOR;
					3'b101: ctrl = alt ? `ALU_SRA : `ALU_SRL; // bit 30 picks arithmetic
					3'b110: ctrl = `ALU_OR;
					3'b111: ctrl = `ALU_AND;
					default: ctrl = `ALU_ADD;
				endcase
			end
			`ALUOP_S, `ALUOP_L:
				ctrl = `ALU_ADD; // address = rs1 + imm
			`ALUOP_B:
			begin
				case (funct3)
					3'b000: ctrl = `ALU_SUBEQ; // beq
					3'b001: ctrl = `ALU_NE;    // bne
					3'b100: ctrl = `ALU_SLT;   // blt
					3'b101: ctrl = `ALU_GE;    // bge
					3'b110: ctrl = `ALU_SLTU;  // bltu
					default: ctrl = `ALU_ADD;  // bgeu not mapped
				endcase
			end
			default: ctrl = `ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/execIfs.sv
`default_nettype none

// operands and control into the ALU, result and condition back out
interface aluCmdIf import rvExecPkg::*;
	();
	aluCtrl_t ctrl;
	word_t    opA;
	word_t    opB;
	word_t    result;
	logic     cond; // branch comparison outcome

	modport issue
	(
		output ctrl, opA, opB,
		input  result, cond
	);

	modport exec
	(
		input  ctrl, opA, opB,
		output result, cond
	);
endinterface

// decoded instruction attributes for the retire stage
interface retireIf import rvExecPkg::*;
	();
	logic     valid;
	logic     regWrite; // R and I classes only
	regAddr_t rd;
	logic     isBranch;
	logic     illegal;
	word_t    target;   // pc + B immediate

	modport issue
	(
		output valid, regWrite, rd, isBranch, illegal, target
	);

	modport retire
	(
		input  valid, regWrite, rd, isBranch, illegal, target
	);
endinterface

`default_nettype wire

// File: rtl/rvExecPkg.sv
`default_nettype none

`include "rvExec_defs.svh"

package rvExecPkg;

	// data, address and instruction words
	typedef logic [`RV_XLEN-1:0] word_t;

	// register file index, x0..x31
	typedef logic [`RV_REG_AW-1:0] regAddr_t;

	// operation class from the opcode decode
	typedef logic [2:0] aluOp_t;

	// code the ALU executes
	typedef logic [3:0] aluCtrl_t;

	// instr[14:12]
	typedef logic [2:0] funct3_t;

endpackage

`default_nettype wire

// File: rtl/rvExec_defs.svh
`ifndef RVEXEC_DEFS_SVH
`define RVEXEC_DEFS_SVH

// datapath widths
`define RV_XLEN   32
`define RV_REG_AW 5

// major opcodes, instr[6:0]
`define OPC_R 7'b0110011
`define OPC_I 7'b0010011
`define OPC_L 7'b0000011
`define OPC_S 7'b0100011
`define OPC_B 7'b1100011

// op classes handed to the ALU control decoder
`define ALUOP_R 3'b000
`define ALUOP_I 3'b001
`define ALUOP_S 3'b010
`define ALUOP_L 3'b011
`define ALUOP_B 3'b100

// ALU control codes
`define ALU_ADD   4'b0000
`define ALU_OR    4'b0001
`define ALU_AND   4'b0010
`define ALU_SLT   4'b0100
`define ALU_SUBEQ 4'b0111
`define ALU_SLL   4'b1000
`define ALU_XOR   4'b1001
`define ALU_SRL   4'b1010
`define ALU_GE    4'b1011
`define ALU_SLTU  4'b1100
`define ALU_SRA   4'b1110
`define ALU_NE    4'b1111

`endif
